/* flist.f */
+incdir+include
hw/cancid_pkg.sv
hw/telnet_login_dfa.sv
hw/ftp_pass_dfa.sv
hw/stream_category_counter.sv
hw/category_alert_merge.sv
hw/cancid_scanner_top.sv
test/cancid_checker.sv
test/cancid_tb.sv

/* test/cancid_tb.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module cancid_tb;

   logic                       clk;
   logic                       rst_n;
   logic [7:0]                 char_in;
   logic                       char_vld;
   logic                       load_state;
   logic                       new_stream_id;
   logic [`CANCID_SID_W-1:0]   stream_id;
   logic                       eop;
   logic                       telnet_en;
   logic                       ftp_en;
   logic [`CANCID_COUNT_W-1:0] telnet_count;
   logic [`CANCID_COUNT_W-1:0] ftp_count;
   logic                       alert_vld;
   cancid_pkg::alert_e         alert_code;
   logic [`CANCID_COUNT_W-1:0] alert_count;

   integer seed;
   int     error_count;
   int     test_count;
   bit     stim_done;
   bit     compare_done;

   // Current packet payload
   logic [7:0] pkt_bytes [0:31];
   int         pkt_len;

   // Reference stream contexts, as prefix lengths matched so far
   int tl_saved [`CANCID_NUM_STREAMS];
   int fp_saved [`CANCID_NUM_STREAMS];
   bit stream_init [`CANCID_NUM_STREAMS];

   // Running expected counts
   int exp_tl_count;
   int exp_fp_count;
   int exp_alert_count;

   // Expectations, one entry per packet in send order
   string exp_name [$];
   int    exp_code [$];
   int    exp_tl [$];
   int    exp_fp [$];
   int    exp_al [$];

   cancid_scanner_top dut_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_vld      (char_vld),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .telnet_en     (telnet_en),
      .ftp_en        (ftp_en),
      .telnet_count  (telnet_count),
      .ftp_count     (ftp_count),
      .alert_vld     (alert_vld),
      .alert_code    (alert_code),
      .alert_count   (alert_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task check_value(input string name, input logic [31:0] expected,
                    input logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   // Prefix length after one byte; a full match restarts like idle
   function int next_prefix(input int s, input logic [7:0] c, input string pat);
      int base;
      base = (s == pat.len()) ? 0 : s;
      if (c == pat[base])
         return base + 1;
      else if (c == pat[0])
         return 1;
      else
         return 0;
   endfunction

   // Runs the current packet through both stream contexts
   function cancid_pkg::alert_e model_packet(input int sid, input bit new_sid,
                                             input bit t_en, input bit f_en,
                                             output bit t_hit, output bit f_hit);
      int ts;
      int fs;
      int i;
      ts = new_sid ? 0 : tl_saved[sid];
      fs = new_sid ? 0 : fp_saved[sid];
      t_hit = 1'b0;
      f_hit = 1'b0;
      for (i = 0; i < pkt_len; i++)
      begin
         ts = next_prefix(ts, pkt_bytes[i], "login:");
         fs = next_prefix(fs, pkt_bytes[i], "PASS ");
         if (ts == 6)
            t_hit = 1'b1;
         if (fs == 5)
            f_hit = 1'b1;
      end
      // Disabled category neither flags nor saves
      t_hit = t_hit & t_en;
      f_hit = f_hit & f_en;
      if (t_en)
         tl_saved[sid] = ts;
      if (f_en)
         fp_saved[sid] = fs;
      if (t_hit && f_hit)
         return cancid_pkg::ALERT_BOTH;
      else if (t_hit)
         return cancid_pkg::ALERT_TELNET;
      else if (f_hit)
         return cancid_pkg::ALERT_FTP;
      else
         return cancid_pkg::ALERT_NONE;
   endfunction

   task load_bytes(input string s);
      int i;
      pkt_len = s.len();
      for (i = 0; i < pkt_len; i++)
         pkt_bytes[i] = s[i];
   endtask

   // Random bytes mixed with fragments of both patterns
   task build_random_packet;
      string alpha;
      string pat;
      int    target;
      int    r;
      int    a;
      int    b;
      int    j;
      alpha = "lognPAS :x";
      pkt_len = 0;
      target = 1 + {$random(seed)} % 14;
      while (pkt_len < target)
      begin
         r = {$random(seed)} % 4;
         if (r < 2)
         begin
            pkt_bytes[pkt_len] = alpha[{$random(seed)} % alpha.len()];
            pkt_len++;
         end
         else
         begin
            if (r == 2)
               pat = "login:";
            else
               pat = "PASS ";
            a = {$random(seed)} % pat.len();
            b = a + {$random(seed)} % (pat.len() - a);
            for (j = a; j <= b && pkt_len < 30; j++)
            begin
               pkt_bytes[pkt_len] = pat[j];
               pkt_len++;
            end
         end
      end
   endtask

   // Model first, then drive load, bytes and eop on falling edges
   task send_packet(input string name, input int sid, input bit new_sid,
                    input bit t_en, input bit f_en);
      bit                 t_hit;
      bit                 f_hit;
      cancid_pkg::alert_e code;
      int                 i;
      code = model_packet(sid, new_sid, t_en, f_en, t_hit, f_hit);
      exp_tl_count += t_hit;
      exp_fp_count += f_hit;
      if (code != cancid_pkg::ALERT_NONE)
         exp_alert_count++;
      exp_name.push_back(name);
      exp_code.push_back(int'(code));
      exp_tl.push_back(exp_tl_count);
      exp_fp.push_back(exp_fp_count);
      exp_al.push_back(exp_alert_count);
      @(negedge clk);
      load_state    = 1'b1;
      new_stream_id = new_sid;
      stream_id     = sid;
      telnet_en     = t_en;
      ftp_en        = f_en;
      @(negedge clk);
      load_state    = 1'b0;
      new_stream_id = 1'b0;
      // First byte lands two cycles after load_state
      for (i = 0; i < pkt_len; i++)
      begin
         @(negedge clk);
         if (({$random(seed)} % 4) == 0)
         begin
            char_vld = 1'b0;
            @(negedge clk);
         end
         char_vld = 1'b1;
         char_in  = pkt_bytes[i];
      end
      @(negedge clk);
      char_vld = 1'b0;
      @(negedge clk);
      eop = 1'b1;
      @(negedge clk);
      eop = 1'b0;
   endtask

   // Compare process, one verdict per queued packet
   initial
   begin
      int    wait_cycles;
      int    errors_before;
      bit    seen;
      string name;
      compare_done = 1'b0;
      while (!(stim_done && exp_name.size() == 0))
      begin
         if (exp_name.size() == 0)
         begin
            @(negedge clk);
            if (rst_n && alert_vld)
            begin
               error_count++;
               $display("alert_vld pulsed with no packet outstanding");
            end
         end
         else
         begin
            wait_cycles = 0;
            seen = 1'b0;
            while (!seen && wait_cycles < 100)
            begin
               @(negedge clk);
               wait_cycles++;
               seen = alert_vld;
            end
            name = exp_name.pop_front();
            errors_before = error_count;
            test_count++;
            if (!seen)
            begin
               error_count++;
               $display("No alert_vld seen for packet %s", name);
               void'(exp_code.pop_front());
               void'(exp_tl.pop_front());
               void'(exp_fp.pop_front());
               void'(exp_al.pop_front());
            end
            else
            begin
               check_value({name, " alert_code"}, exp_code.pop_front(), alert_code);
               check_value({name, " telnet_count"}, exp_tl.pop_front(), telnet_count);
               check_value({name, " ftp_count"}, exp_fp.pop_front(), ftp_count);
               check_value({name, " alert_count"}, exp_al.pop_front(), alert_count);
            end
            $display("test %-16s %s", name, (error_count == errors_before) ? "ok" : "failed");
         end
      end
      compare_done = 1'b1;
   end

   initial
   begin
      int sid;
      int n;
      int wait_cycles;
      int errors_before;
      bit new_sid;
      bit t_en;
      bit f_en;
      seed = 96050;
      error_count = 0;
      test_count = 0;
      stim_done = 1'b0;
      exp_tl_count = 0;
      exp_fp_count = 0;
      exp_alert_count = 0;
      for (n = 0; n < `CANCID_NUM_STREAMS; n++)
      begin
         tl_saved[n] = 0;
         fp_saved[n] = 0;
         stream_init[n] = 1'b0;
      end
      rst_n         = 1'b0;
      char_in       = 8'h00;
      char_vld      = 1'b0;
      load_state    = 1'b0;
      new_stream_id = 1'b0;
      stream_id     = '0;
      eop           = 1'b0;
      telnet_en     = 1'b0;
      ftp_en        = 1'b0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      // Quiet outputs after reset
      errors_before = error_count;
      test_count++;
      repeat (3) @(negedge clk);
      check_value("reset telnet_count", 0, telnet_count);
      check_value("reset ftp_count", 0, ftp_count);
      check_value("reset alert_count", 0, alert_count);
      check_value("reset alert_code", cancid_pkg::ALERT_NONE, alert_code);
      check_value("reset alert_vld", 0, alert_vld);
      $display("test %-16s %s", "reset", (error_count == errors_before) ? "ok" : "failed");

      // Single and double category hits
      load_bytes("xlogin:z");
      send_packet("login_new", 1, 1'b1, 1'b1, 1'b1);
      load_bytes("PASS login:");
      send_packet("both_patterns", 2, 1'b1, 1'b1, 1'b1);
      // Saved hit state alone does not flag the next packet
      load_bytes("zz");
      send_packet("after_hit", 2, 1'b0, 1'b1, 1'b1);

      // Pattern split over two packets of one stream
      load_bytes("xxlog");
      send_packet("split_first", 5, 1'b1, 1'b1, 1'b1);
      load_bytes("in:yy");
      send_packet("split_second", 5, 1'b0, 1'b1, 1'b1);
      // Same split but the stream restarts
      load_bytes("log");
      send_packet("restart_first", 6, 1'b1, 1'b1, 1'b1);
      load_bytes("in:");
      send_packet("restart_second", 6, 1'b1, 1'b1, 1'b1);

      // FTP disabled packet must leave the saved "PAS" prefix alone
      load_bytes("xPAS");
      send_packet("ftp_prefix", 7, 1'b1, 1'b1, 1'b1);
      load_bytes("PASS ");
      send_packet("ftp_disabled", 7, 1'b0, 1'b1, 1'b0);
      load_bytes("S ");
      send_packet("ftp_resume", 7, 1'b0, 1'b1, 1'b1);

      // Interleaved random traffic on four streams
      for (n = 0; n < 40; n++)
      begin
         sid = 8 + {$random(seed)} % 4;
         build_random_packet();
         if (!stream_init[sid])
         begin
            // First packet seeds both contexts of the stream
            new_sid = 1'b1;
            t_en = 1'b1;
            f_en = 1'b1;
            stream_init[sid] = 1'b1;
         end
         else
         begin
            new_sid = ({$random(seed)} % 8) == 0;
            t_en = {$random(seed)} % 2;
            f_en = {$random(seed)} % 2;
         end
         send_packet($sformatf("random_%0d", n), sid, new_sid, t_en, f_en);
      end
      stim_done = 1'b1;

      wait_cycles = 0;
      while (!compare_done && wait_cycles < 300)
      begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!compare_done)
      begin
         error_count++;
         $display("Compare process did not finish within 300 cycles");
      end
      $display("Tests: %0d, errors: %0d", test_count, error_count);
      if (error_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* test/cancid_checker.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module cancid_checker (
   input logic                       clk,
   input logic                       rst_n,
   input logic                       eop,
   input logic                       alert_vld,
   input logic [1:0]                 alert_code,
   input logic [`CANCID_COUNT_W-1:0] telnet_count,
   input logic [`CANCID_COUNT_W-1:0] ftp_count,
   input logic [`CANCID_COUNT_W-1:0] alert_count
);

   // Verdict pulse lands exactly two cycles after eop, and never otherwise
   a_alert_timing: assert property (@(posedge clk) disable iff (!rst_n)
      alert_vld == $past(eop, 2))
      else $error("alert_vld is not two cycles after eop");

   // Category counts move only in the cycle after eop
   a_telnet_count: assert property (@(posedge clk) disable iff (!rst_n)
      (telnet_count != $past(telnet_count)) |-> $past(eop))
      else $error("telnet_count changed outside the eop window");

   a_ftp_count: assert property (@(posedge clk) disable iff (!rst_n)
      (ftp_count != $past(ftp_count)) |-> $past(eop))
      else $error("ftp_count changed outside the eop window");

   // Alert count steps together with the verdict pulse
   a_alert_count: assert property (@(posedge clk) disable iff (!rst_n)
      (alert_count != $past(alert_count)) |-> alert_vld)
      else $error("alert_count changed without alert_vld");

   // Synchronous reset clears every output one edge later
   a_reset_zero: assert property (@(posedge clk)
      !rst_n |=> (telnet_count == 0 && ftp_count == 0 && alert_count == 0
                  && !alert_vld && alert_code == 2'd0))
      else $error("outputs not cleared by reset");

endmodule

bind cancid_scanner_top cancid_checker checker_i (
   .clk          (clk),
   .rst_n        (rst_n),
   .eop          (eop),
   .alert_vld    (alert_vld),
   .alert_code   (alert_code),
   .telnet_count (telnet_count),
   .ftp_count    (ftp_count),
   .alert_count  (alert_count)
);

/* hw/cancid_scanner_top.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module cancid_scanner_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [7:0]                 char_in,
   input  logic                       char_vld,
   input  logic                       load_state,
   input  logic                       new_stream_id,
   input  logic [`CANCID_SID_W-1:0]   stream_id,
   input  logic                       eop,
   input  logic                       telnet_en,
   input  logic                       ftp_en,
   output logic [`CANCID_COUNT_W-1:0] telnet_count,
   output logic [`CANCID_COUNT_W-1:0] ftp_count,
   output logic                       alert_vld,
   output cancid_pkg::alert_e         alert_code,
   output logic [`CANCID_COUNT_W-1:0] alert_count
);

   // Per-packet verdicts, one cycle after eop
   logic telnet_hit;
   logic ftp_hit;

   stream_category_counter #(
      .CATEGORY (cancid_pkg::CAT_TELNET)
   ) telnet_ctr_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_vld      (char_vld),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .enable        (telnet_en),
      .hit           (telnet_hit),
      .pkt_count     (telnet_count)
   );

   stream_category_counter #(
      .CATEGORY (cancid_pkg::CAT_FTP)
   ) ftp_ctr_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_vld      (char_vld),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .enable        (ftp_en),
      .hit           (ftp_hit),
      .pkt_count     (ftp_count)
   );

   // Alert lands two cycles after eop
   category_alert_merge merge_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .eop         (eop),
      .telnet_hit  (telnet_hit),
      .ftp_hit     (ftp_hit),
      .alert_vld   (alert_vld),
      .alert_code  (alert_code),
      .alert_count (alert_count)
   );

endmodule

/* hw/category_alert_merge.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module category_alert_merge (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       eop,
   input  logic                       telnet_hit,
   input  logic                       ftp_hit,
   output logic                       alert_vld,
   output cancid_pkg::alert_e         alert_code,
   output logic [`CANCID_COUNT_W-1:0] alert_count
);

   // eop delayed to the cycle of the hit pulses
   logic               eop_q;
   cancid_pkg::alert_e next_code;

   always_comb
   begin
      case ({ftp_hit, telnet_hit})
         2'b01:   next_code = cancid_pkg::ALERT_TELNET;
         2'b10:   next_code = cancid_pkg::ALERT_FTP;
         2'b11:   next_code = cancid_pkg::ALERT_BOTH;
         default: next_code = cancid_pkg::ALERT_NONE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         eop_q       <= 1'b0;
         alert_vld   <= 1'b0;
         alert_code  <= cancid_pkg::ALERT_NONE;
         alert_count <= '0;
      end
      else
      begin
         eop_q     <= eop;
         alert_vld <= eop_q;
         // Code holds until the next packet verdict
         if (eop_q)
         begin
            alert_code <= next_code;
            if (next_code != cancid_pkg::ALERT_NONE)
               alert_count <= alert_count + 1'b1;
         end
      end
   end

endmodule

/* hw/stream_category_counter.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module stream_category_counter #(
   parameter cancid_pkg::category_e CATEGORY = cancid_pkg::CAT_TELNET
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [7:0]                 char_in,
   input  logic                       char_vld,
   input  logic                       load_state,
   input  logic                       new_stream_id,
   input  logic [`CANCID_SID_W-1:0]   stream_id,
   input  logic                       eop,
   input  logic                       enable,
   output logic                       hit,
   output logic [`CANCID_COUNT_W-1:0] pkt_count
);

   // Saved matcher state per stream
   logic [`CANCID_STATE_W-1:0] state_mem [`CANCID_NUM_STREAMS];

   logic [`CANCID_STATE_W-1:0] state_in;
   logic [`CANCID_STATE_W-1:0] state_out;
   logic                       state_in_vld;
   logic                       accept;
   logic                       char_vld_q;
   logic                       match_flag;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
         char_vld_q   <= 1'b0;
         match_flag   <= 1'b0;
         hit          <= 1'b0;
         pkt_count    <= '0;
      end
      else
      begin
         // Matcher loads one cycle after load_state
         state_in_vld <= load_state;
         char_vld_q   <= char_vld;
         hit          <= 1'b0;
         // New packet, no match yet
         if (load_state)
            match_flag <= 1'b0;
         // Only a byte that just completed the pattern counts
         // A restored hit state must not flag the packet
         if (accept && char_vld_q)
            match_flag <= 1'b1;
         if (eop)
         begin
            if (enable)
            begin
               pkt_count <= pkt_count + {{(`CANCID_COUNT_W-1){1'b0}}, match_flag};
               hit       <= match_flag;
            end
            else
               match_flag <= 1'b0;
         end
      end
   end

   // Context restore at packet start and save at enabled eop
   always_ff @(posedge clk)
   begin
      if (load_state)
         state_in <= new_stream_id ? '0 : state_mem[stream_id];
      // Disabled packets leave the stream context untouched
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   generate
      if (CATEGORY == cancid_pkg::CAT_TELNET)
      begin : g_telnet
         telnet_login_dfa dfa_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .char_in      (char_in),
            .char_vld     (char_vld),
            .state_in     (state_in),
            .state_in_vld (state_in_vld),
            .state_out    (state_out),
            .accept       (accept)
         );
      end
      else
      begin : g_ftp
         ftp_pass_dfa dfa_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .char_in      (char_in),
            .char_vld     (char_vld),
            .state_in     (state_in),
            .state_in_vld (state_in_vld),
            .state_out    (state_out),
            .accept       (accept)
         );
      end
   endgenerate

endmodule

/* hw/ftp_pass_dfa.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module ftp_pass_dfa (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [7:0]                 char_in,
   input  logic                       char_vld,
   input  logic [`CANCID_STATE_W-1:0] state_in,
   input  logic                       state_in_vld,
   output logic [`CANCID_STATE_W-1:0] state_out,
   output logic                       accept
);

   cancid_pkg::ftp_state_e state;
   cancid_pkg::ftp_state_e base;
   cancid_pkg::ftp_state_e next_state;

   always_comb
   begin
      // After a hit the next byte sees an idle matcher
      base = (state == cancid_pkg::FP_HIT) ? cancid_pkg::FP_IDLE : state;
      // Restart on 'P', otherwise drop back to idle
      next_state = (char_in == "P") ? cancid_pkg::FP_P : cancid_pkg::FP_IDLE;
      case (base)
         cancid_pkg::FP_P:
            if (char_in == "A")
               next_state = cancid_pkg::FP_PA;
         cancid_pkg::FP_PA:
            if (char_in == "S")
               next_state = cancid_pkg::FP_PAS;
         cancid_pkg::FP_PAS:
            if (char_in == "S")
               next_state = cancid_pkg::FP_PASS;
         // Pattern ends with a space
         cancid_pkg::FP_PASS:
            if (char_in == " ")
               next_state = cancid_pkg::FP_HIT;
         default:
            ;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= cancid_pkg::FP_IDLE;
      else if (state_in_vld)
         state <= cancid_pkg::ftp_state_e'(state_in);
      else if (char_vld)
         state <= next_state;
   end

   assign state_out = state;
   assign accept = (state == cancid_pkg::FP_HIT);

endmodule

/* hw/telnet_login_dfa.sv */
`timescale 1ns/1ns
`include "cancid_config.svh"

module telnet_login_dfa (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [7:0]                 char_in,
   input  logic                       char_vld,
   input  logic [`CANCID_STATE_W-1:0] state_in,
   input  logic                       state_in_vld,
   output logic [`CANCID_STATE_W-1:0] state_out,
   output logic                       accept
);

   cancid_pkg::telnet_state_e state;
   cancid_pkg::telnet_state_e base;
   cancid_pkg::telnet_state_e next_state;

   always_comb
   begin
      // A completed match starts over like an idle matcher
      base = (state == cancid_pkg::TL_HIT) ? cancid_pkg::TL_IDLE : state;
      // Mismatch fallback, 'l' may begin a new match
      next_state = (char_in == "l") ? cancid_pkg::TL_L : cancid_pkg::TL_IDLE;
      case (base)
         cancid_pkg::TL_L:
            if (char_in == "o")
               next_state = cancid_pkg::TL_LO;
         cancid_pkg::TL_LO:
            if (char_in == "g")
               next_state = cancid_pkg::TL_LOG;
         cancid_pkg::TL_LOG:
            if (char_in == "i")
               next_state = cancid_pkg::TL_LOGI;
         cancid_pkg::TL_LOGI:
            if (char_in == "n")
               next_state = cancid_pkg::TL_LOGIN;
         cancid_pkg::TL_LOGIN:
            if (char_in == ":")
               next_state = cancid_pkg::TL_HIT;
         // Idle is covered by the fallback
         default:
            ;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= cancid_pkg::TL_IDLE;
      // Restored context wins over a byte
      else if (state_in_vld)
         state <= cancid_pkg::telnet_state_e'(state_in);
      else if (char_vld)
         state <= next_state;
   end

   assign state_out = state;
   // High in the cycle after the closing ':'
   assign accept = (state == cancid_pkg::TL_HIT);

endmodule

/* hw/cancid_pkg.sv */
`include "cancid_config.svh"

package cancid_pkg;

   // Telnet matcher, one state per matched prefix of "login:"
   typedef enum logic [`CANCID_STATE_W-1:0] {
      TL_IDLE = 0,
      TL_L,
      TL_LO,
      TL_LOG,
      TL_LOGI,
      TL_LOGIN,
      TL_HIT
   } telnet_state_e;

   // FTP matcher, one state per matched prefix of "PASS "
   typedef enum logic [`CANCID_STATE_W-1:0] {
      FP_IDLE = 0,
      FP_P,
      FP_PA,
      FP_PAS,
      FP_PASS,
      FP_HIT
   } ftp_state_e;

   // Selects the matcher inside a category counter
   typedef enum logic {
      CAT_TELNET,
      CAT_FTP
   } category_e;

   // Per-packet verdict, bit 0 telnet and bit 1 FTP
   typedef enum logic [1:0] {
      ALERT_NONE   = 2'd0,
      ALERT_TELNET = 2'd1,
      ALERT_FTP    = 2'd2,
      ALERT_BOTH   = 2'd3
   } alert_e;

endpackage

/* include/cancid_config.svh */
`ifndef CANCID_CONFIG_SVH
`define CANCID_CONFIG_SVH

// Number of stream contexts held per category
`define CANCID_NUM_STREAMS 64

// Stream id width, enough to address every context
`define CANCID_SID_W 6

// Width of the packet and alert counters
`define CANCID_COUNT_W 16

// Width of one saved matcher state
// Must hold every state of both matchers
`define CANCID_STATE_W 4

`endif
